// ==== list.f ====
+incdir+sim
logic/ecc_pkg.sv
logic/ecc_syndrome.sv
logic/ecc_correct.sv
logic/ecc_rsp_buffer.sv
logic/ecc_ctrl.sv
logic/ecc_unit.sv
sim/ecc_unit_tb.sv

// ==== Bender.yml ====
package:
  name: ecc_unit

sources:
  - logic/ecc_pkg.sv
  - logic/ecc_syndrome.sv
  - logic/ecc_correct.sv
  - logic/ecc_rsp_buffer.sv
  - logic/ecc_ctrl.sv
  - logic/ecc_unit.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ecc_unit_tb.sv

// ==== sim/ecc_unit_tests.svh ====
/*
   ECC word unit directed tests
   each task sends requests, queues the expected responses
   and waits until the checker has seen them all
*/
`ifndef ECC_UNIT_TESTS_SVH
`define ECC_UNIT_TESTS_SVH

   // starts on a falling edge and returns on the next one
   task automatic send_req(input ecc_req_t req, input ecc_rsp_t want);
      while (up_credits == 0)
         @(negedge clk);
      in_valid = 1'b1;
      in_req = req;
      exp_q.push_back(want);
      up_credits--;
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      check_cond(exp_q.size() == 0, "responses still missing after the drain wait");
      repeat (2) @(negedge clk);   // lets the last in_credit pulse land
   endtask

   task automatic end_test(input string name, input int err_before, input int nreq);
      tests_run++;
      if (errors == err_before)
         $display("%-12s pass, %0d requests", name, nreq);
      else begin
         tests_failed++;
         $display("%-12s FAIL, %0d errors", name, errors - err_before);
      end
   endtask

   // encode must ignore whatever sits in the ecc field of the request
   task automatic test_encode();
      int err0;
      data_t d;
      ecc_t e;
      logic [31:0] rnd;
      err0 = errors;
      for (int i = 0; i < N_ENCODE; i++) begin
         d = lcg_next();
         rnd = lcg_next();
         e = rnd[30:24];
         send_req(make_req(OP_ENCODE, d, e, 1'b0), make_rsp(d, model_encode(d), 1'b0, 1'b0));
      end
      wait_drain();
      end_test("encode", err0, N_ENCODE);
   endtask

   task automatic test_clean();
      int err0;
      data_t d;
      ecc_t e;
      err0 = errors;
      for (int i = 0; i < N_CLEAN; i++) begin
         d = lcg_next();
         e = model_encode(d);
         send_req(make_req(OP_CHECK, d, e, 1'b0), make_rsp(d, e, 1'b0, 1'b0));
      end
      wait_drain();
      end_test("clean check", err0, N_CLEAN);
   endtask

   task automatic test_single();
      int err0;
      data_t d;
      data_t bd;
      ecc_t e;
      ecc_t be;
      err0 = errors;
      for (int pos = 1; pos <= CODE_BITS; pos++) begin
         d = lcg_next();
         e = model_encode(d);
         bd = d;
         be = e;
         flip_pos(bd, be, pos);
         send_req(make_req(OP_CHECK, bd, be, 1'b0), make_rsp(d, e, 1'b1, 1'b0));
      end
      wait_drain();
      end_test("single error", err0, CODE_BITS);
   endtask

   // p2 lies 1 to CODE_BITS-1 places after p1 so the two never match
   task automatic test_double();
      int err0;
      int p1;
      int p2;
      data_t bd;
      ecc_t be;
      err0 = errors;
      for (int i = 0; i < N_DOUBLE; i++) begin
         bd = lcg_next();
         be = model_encode(bd);
         p1 = (lcg_next() >> 8) % CODE_BITS + 1;
         p2 = (p1 + (lcg_next() >> 8) % (CODE_BITS - 1)) % CODE_BITS + 1;
         flip_pos(bd, be, p1);
         flip_pos(bd, be, p2);
         send_req(make_req(OP_CHECK, bd, be, 1'b0), make_rsp(bd, be, 1'b0, 1'b1));
      end
      wait_drain();
      end_test("double error", err0, N_DOUBLE);
   endtask

   task automatic test_sed_ded();
      int err0;
      data_t bd;
      ecc_t be;
      err0 = errors;
      for (int i = 0; i < N_SED; i++) begin
         bd = lcg_next();
         be = model_encode(bd);
         flip_pos(bd, be, (lcg_next() >> 8) % CODE_BITS + 1);
         send_req(make_req(OP_CHECK, bd, be, 1'b1), make_rsp(bd, be, 1'b0, 1'b1));
      end
      wait_drain();
      end_test("detect only", err0, N_SED);
   endtask

   task automatic test_credit_flow();
      int err0;
      int rsp0;
      int crd0;
      int waited;
      data_t d;
      err0 = errors;
      auto_grant = 1'b0;
      check_cond(up_credits == BUF_DEPTH, "upstream credits not all returned before credit test");
      rsp0 = rsp_count;
      crd0 = in_credit_count;
      for (int i = 0; i < BUF_DEPTH; i++) begin
         d = lcg_next();
         send_req(make_req(OP_ENCODE, d, '0, 1'b0), make_rsp(d, model_encode(d), 1'b0, 1'b0));
      end
      repeat (12) @(negedge clk);
      check_cond(rsp_count == rsp0, "response sent without an output credit");
      check_cond(in_credit_count == crd0, "in_credit pulsed while the buffer was held");
      check_cond(up_credits == 0, "upstream still holds credits with the buffer full");
      for (int i = 0; i < BUF_DEPTH; i++) begin
         rsp0 = rsp_count;
         crd0 = in_credit_count;
         grant_req++;
         waited = 0;
         while (in_credit_count == crd0 && waited < 20) begin
            @(negedge clk);
            waited++;
         end
         repeat (3) @(negedge clk);
         check_cond(rsp_count == rsp0 + 1, "one output credit did not give exactly one response");
         check_cond(in_credit_count == crd0 + 1, "one response did not return exactly one credit");
      end
      auto_grant = 1'b1;
      wait_drain();
      end_test("credit flow", err0, BUF_DEPTH);
   endtask

`endif

// ==== sim/ecc_unit_tb.sv ====
/*
   ECC word unit testbench
   clock, reset, credit tracking for both clients, response checker
   and a model of the SECDED code
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_unit_tb import ecc_pkg::*; ();

   localparam int BUF_DEPTH = 4;
   localparam int MAX_OUT_CREDITS = 8;
   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 16;
   localparam int N_ENCODE = 32;
   localparam int N_CLEAN = 16;
   localparam int N_DOUBLE = 20;
   localparam int N_SED = 16;
   localparam int TOTAL_REQS = N_ENCODE + N_CLEAN + CODE_BITS + N_DOUBLE + N_SED + BUF_DEPTH;

   logic clk = 1'b0;
   logic rst_l;
   logic in_valid;
   ecc_req_t in_req;
   logic in_credit;
   logic out_valid;
   ecc_rsp_t out_rsp;
   logic out_credit;

   ecc_rsp_t exp_q[$];               // expected responses in request order
   int up_credits = BUF_DEPTH;       // credits held by the upstream client
   int held = 0;                     // output credits granted and not yet spent
   int grant_req = 0;                // single grants asked for by a test
   logic grant_next = 1'b0;
   bit auto_grant = 1'b1;
   int rsp_count = 0;
   int in_credit_count = 0;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   logic [31:0] lcg_state = 32'd55;

   ecc_unit #(
      .BUF_DEPTH       (BUF_DEPTH),
      .MAX_OUT_CREDITS (MAX_OUT_CREDITS)
   ) ecc_unit_inst (
      .clk        (clk),
      .rst_l      (rst_l),
      .in_valid   (in_valid),
      .in_req     (in_req),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_rsp    (out_rsp),
      .out_credit (out_credit)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // check bit j is the xor of the data bits at positions with bit j set
   function automatic ecc_t model_encode(input data_t d);
      ecc_t e;
      int di;
      e = '0;
      di = 0;
      for (int p = 1; p < CODE_BITS; p++) begin
         if ($countones(p) != 1) begin
            for (int j = 0; j < 6; j++) begin
               if (p[j])
                  e[j] = e[j] ^ d[di];
            end
            di++;
         end
      end
      e[6] = (^d) ^ (^e[5:0]);
      return e;
   endfunction

   // position CODE_BITS is the overall parity bit
   function automatic void flip_pos(inout data_t d, inout ecc_t e, input int pos);
      int lg;
      lg = 0;
      while ((1 << (lg + 1)) <= pos)
         lg++;
      if (pos == CODE_BITS)
         e[6] = ~e[6];
      else if ($countones(pos) == 1)
         e[lg] = ~e[lg];
      else
         d[pos - lg - 2] = ~d[pos - lg - 2];   // skip the lg+1 check positions below
   endfunction

   function automatic ecc_req_t make_req(input ecc_op_e op, input data_t d, input ecc_t e,
                                         input logic sed);
      ecc_req_t r;
      r.op = op;
      r.data = d;
      r.ecc = e;
      r.sed_ded = sed;
      return r;
   endfunction

   function automatic ecc_rsp_t make_rsp(input data_t d, input ecc_t e, input logic s,
                                         input logic dbl);
      ecc_rsp_t r;
      r.data = d;
      r.ecc = e;
      r.single_err = s;
      r.double_err = dbl;
      return r;
   endfunction

   function automatic void check_value(input string name, input logic [31:0] got,
                                       input logic [31:0] want);
      assert (got === want)
      else begin
         $display("Error: %s got 0x%0h, expected 0x%0h", name, got, want);
         errors++;
      end
   endfunction

   function automatic void check_cond(input bit ok, input string what);
      assert (ok)
      else begin
         $display("%s", what);
         errors++;
      end
   endfunction

   `include "ecc_unit_tests.svh"

   // outputs sampled at the rising edge, before the DUT registers move
   always @(posedge clk) begin : monitor
      ecc_rsp_t want;
      if (rst_l) begin
         if (out_valid) begin
            rsp_count++;
            held--;
            check_cond(exp_q.size() != 0, "response arrived with no request outstanding");
            if (exp_q.size() != 0) begin
               want = exp_q.pop_front();
               check_value("out_rsp.data", out_rsp.data, want.data);
               check_value("out_rsp.ecc", out_rsp.ecc, want.ecc);
               check_value("out_rsp.single_err", out_rsp.single_err, want.single_err);
               check_value("out_rsp.double_err", out_rsp.double_err, want.double_err);
            end
         end
         if (in_credit) begin
            in_credit_count++;
            up_credits++;
            check_cond(up_credits <= BUF_DEPTH, "upstream got more credits than buffer slots");
         end
         grant_next = 1'b0;
         if (grant_req > 0) begin
            grant_next = 1'b1;
            grant_req--;
            held++;
         end
         else if (auto_grant && held < exp_q.size() && held < MAX_OUT_CREDITS) begin
            grant_next = 1'b1;
            held++;
         end
      end
   end

   always @(negedge clk) out_credit = grant_next;

   initial begin
      rst_l = 1'b0;
      in_valid = 1'b0;
      in_req = '0;
      out_credit = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_l = 1'b1;
      @(negedge clk);
      test_encode();
      test_clean();
      test_single();
      test_double();
      test_sed_ded();
      test_credit_flow();
      $display("%0d tests run, %0d failed, %0d responses, %0d errors",
               tests_run, tests_failed, rsp_count, errors);
      if (errors == 0 && tests_failed == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial begin : watchdog
      #(RESET_CYCLES * CLK_PERIOD + TOTAL_REQS * 10 * CLK_PERIOD);
      $display("timeout, the run did not finish in time");
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/ecc_unit.sv ====
/*
   ECC word unit top level
   two stage SECDED encode/check pipeline feeding a response buffer,
   credit flow control towards both clients
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_unit import ecc_pkg::*; #(
   parameter int BUF_DEPTH = 4,
   parameter int MAX_OUT_CREDITS = 8
) (
   input  logic     clk,
   input  logic     rst_l,
   input  logic     in_valid,
   input  ecc_req_t in_req,
   output logic     in_credit,
   output logic     out_valid,
   output ecc_rsp_t out_rsp,
   input  logic     out_credit
);

   logic s1_valid;
   logic push;
   logic pop;
   ecc_stage_t stage;
   ecc_rsp_t corr_rsp;

   ecc_ctrl #(
      .BUF_DEPTH       (BUF_DEPTH),
      .MAX_OUT_CREDITS (MAX_OUT_CREDITS)
   ) ecc_ctrl_inst (
      .clk        (clk),
      .rst_l      (rst_l),
      .in_valid   (in_valid),
      .out_credit (out_credit),
      .s1_valid   (s1_valid),
      .s2_valid   (),               // same timing as push
      .push       (push),
      .pop        (pop),
      .out_valid  (out_valid),
      .in_credit  (in_credit)
   );

   ecc_syndrome ecc_syndrome_inst (
      .clk      (clk),
      .rst_l    (rst_l),
      .in_valid (in_valid),
      .in_req   (in_req),
      .stage    (stage)
   );

   ecc_correct ecc_correct_inst (
      .clk         (clk),
      .rst_l       (rst_l),
      .stage_valid (s1_valid),
      .stage       (stage),
      .rsp         (corr_rsp)
   );

   ecc_rsp_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) ecc_rsp_buffer_inst (
      .clk    (clk),
      .rst_l  (rst_l),
      .push   (push),
      .pop    (pop),
      .wr_rsp (corr_rsp),
      .rd_rsp (out_rsp)
   );

endmodule

`default_nettype wire

// ==== logic/ecc_ctrl.sv ====
/*
   ECC unit control
   stage valid bits, response buffer occupancy and the credit counters
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_ctrl #(
   parameter int BUF_DEPTH = 4,
   parameter int MAX_OUT_CREDITS = 8
) (
   input  logic clk,
   input  logic rst_l,
   input  logic in_valid,
   input  logic out_credit,
   output logic s1_valid,
   output logic s2_valid,
   output logic push,
   output logic pop,
   output logic out_valid,
   output logic in_credit
);

   localparam int OCC_W = $clog2(BUF_DEPTH + 1);
   localparam int CRD_W = $clog2(MAX_OUT_CREDITS + 1);

   logic [OCC_W-1:0] occupancy;
   logic [CRD_W-1:0] out_credits;

   assign push = s2_valid;                  // stage two result lands in the buffer
   assign pop = (occupancy != '0) && (out_credits != '0);
   assign out_valid = pop;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         in_credit <= 1'b0;
      end
      else begin
         s1_valid <= in_valid;
         s2_valid <= s1_valid;
         in_credit <= pop;                  // slot freed, hand the credit back
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         occupancy <= '0;
      end
      else if (push && !pop) begin
         occupancy <= occupancy + 1'b1;
      end
      else if (pop && !push) begin
         occupancy <= occupancy - 1'b1;
      end
   end

   // downstream grants one credit per out_credit pulse
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         out_credits <= '0;
      end
      else if (out_credit && !pop) begin
         out_credits <= out_credits + 1'b1;
      end
      else if (pop && !out_credit) begin
         out_credits <= out_credits - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/ecc_rsp_buffer.sv ====
/*
   ECC response buffer
   circular store of finished responses, oldest entry always on rd_rsp
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_rsp_buffer import ecc_pkg::*; #(
   parameter int BUF_DEPTH = 4
) (
   input  logic     clk,
   input  logic     rst_l,
   input  logic     push,
   input  logic     pop,
   input  ecc_rsp_t wr_rsp,
   output ecc_rsp_t rd_rsp
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST = PTR_W'(BUF_DEPTH - 1);

   ecc_rsp_t mem [BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   // overflow cannot happen, upstream holds one credit per entry
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_rsp;
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;   // wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   assign rd_rsp = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/ecc_correct.sv ====
/*
   ECC pipeline stage two
   classifies single and double errors from the syndrome and parity,
   flips a single bad codeword bit and registers the response
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_correct import ecc_pkg::*; (
   input  logic       clk,
   input  logic       rst_l,
   input  logic       stage_valid,
   input  ecc_stage_t stage,
   output ecc_rsp_t   rsp
);

   logic [CODE_BITS-1:0] cw_in;
   logic [CODE_BITS-1:0] cw_fix;
   data_t fix_data;
   ecc_t fix_ecc;
   logic is_check;
   logic nonzero;
   logic single_err;
   logic double_err;
   ecc_rsp_t rsp_d;

   // received codeword with position p in bit p-1 and the overall parity on top
   always_comb begin : pack_cw
      int unsigned dbit;
      int unsigned cbit;
      dbit = 0;
      cbit = 0;
      for (int pos = 1; pos < CODE_BITS; pos++) begin
         if ((pos & (pos - 1)) == 0) begin
            cw_in[pos-1] = stage.req.ecc[cbit];
            cbit++;
         end
         else begin
            cw_in[pos-1] = stage.req.data[dbit];
            dbit++;
         end
      end
      cw_in[CODE_BITS-1] = stage.req.ecc[ECC_W-1];
   end

   assign is_check = (stage.req.op == OP_CHECK);
   assign nonzero = (stage.syndrome != '0) | stage.parity_err;

   // in detect only mode every nonzero result counts as a double error
   assign single_err = is_check & ~stage.req.sed_ded & stage.parity_err;
   assign double_err = is_check & nonzero & (stage.req.sed_ded | ~stage.parity_err);

   always_comb begin
      cw_fix = cw_in;
      if (single_err) begin
         if (stage.syndrome == '0) begin
            cw_fix[CODE_BITS-1] = ~cw_in[CODE_BITS-1];   // only the parity bit flipped
         end
         for (int pos = 1; pos < CODE_BITS; pos++) begin
            if (stage.syndrome == SYN_W'(pos)) begin
               cw_fix[pos-1] = ~cw_in[pos-1];
            end
         end
      end
   end

   always_comb begin : unpack_cw
      int unsigned dbit;
      int unsigned cbit;
      dbit = 0;
      cbit = 0;
      fix_data = '0;
      fix_ecc = '0;
      for (int pos = 1; pos < CODE_BITS; pos++) begin
         if ((pos & (pos - 1)) == 0) begin
            fix_ecc[cbit] = cw_fix[pos-1];
            cbit++;
         end
         else begin
            fix_data[dbit] = cw_fix[pos-1];
            dbit++;
         end
      end
      fix_ecc[ECC_W-1] = cw_fix[CODE_BITS-1];
   end

   always_comb begin
      rsp_d.data = fix_data;                 // untouched unless a single error was fixed
      rsp_d.single_err = single_err;
      rsp_d.double_err = double_err;
      if (is_check) begin
         rsp_d.ecc = fix_ecc;
      end
      else begin
         rsp_d.ecc = {stage.parity_err, stage.syndrome};  // generated code
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp <= '0;
      end
      else if (stage_valid) begin
         rsp <= rsp_d;
      end
   end

endmodule

`default_nettype wire

// ==== logic/ecc_syndrome.sv ====
/*
   ECC pipeline stage one
   recomputes the hamming check bits from the data word and forms either
   the generated check bits (encode) or the syndrome (check)
*/
`timescale 1ns/100ps
`default_nettype none

module ecc_syndrome import ecc_pkg::*; (
   input  logic       clk,
   input  logic       rst_l,
   input  logic       in_valid,
   input  ecc_req_t   in_req,
   output ecc_stage_t stage
);

   syndrome_t check;
   ecc_stage_t stage_d;

   // check bit j covers every data bit whose codeword position has bit j set
   always_comb begin : calc_check
      int unsigned dbit;
      dbit = 0;
      check = '0;
      for (int pos = 1; pos < CODE_BITS; pos++) begin
         if ((pos & (pos - 1)) != 0) begin   // powers of two hold check bits
            for (int j = 0; j < SYN_W; j++) begin
               if (pos[j]) begin
                  check[j] = check[j] ^ in_req.data[dbit];
               end
            end
            dbit++;
         end
      end
   end

   always_comb begin
      stage_d.req = in_req;
      if (in_req.op == OP_CHECK) begin
         stage_d.syndrome = check ^ in_req.ecc[SYN_W-1:0];
         stage_d.parity_err = (^in_req.data) ^ (^in_req.ecc);  // over whole codeword
      end
      else begin
         stage_d.syndrome = check;
         stage_d.parity_err = (^in_req.data) ^ (^check);       // generated parity bit
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         stage <= '0;
      end
      else if (in_valid) begin
         stage <= stage_d;
      end
   end

endmodule

`default_nettype wire

// ==== logic/ecc_pkg.sv ====
/*
   ECC word unit shared definitions
   widths, operation codes and the request, stage and response words
   for the 32-bit SECDED path (6 hamming check bits + overall parity)
*/
`default_nettype none

package ecc_pkg;

   localparam int DATA_W = 32;
   localparam int ECC_W = 7;                  // 6 check bits + overall parity
   localparam int SYN_W = 6;
   localparam int CODE_BITS = DATA_W + ECC_W; // full codeword length

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ECC_W-1:0] ecc_t;           // [5:0] hamming, [6] overall parity
   typedef logic [SYN_W-1:0] syndrome_t;

   // one bit opcode carried with each request
   typedef enum logic {
      OP_ENCODE = 1'b0,
      OP_CHECK = 1'b1
   } ecc_op_e;

   typedef struct packed {
      ecc_op_e op;
      data_t data;
      ecc_t ecc;
      logic sed_ded;                          // detect only, no correction
   } ecc_req_t;

   // stage one result
   // for an encode the syndrome field holds the generated check bits
   // and parity_err holds the generated parity bit
   typedef struct packed {
      ecc_req_t req;
      syndrome_t syndrome;
      logic parity_err;
   } ecc_stage_t;

   typedef struct packed {
      data_t data;
      ecc_t ecc;
      logic single_err;
      logic double_err;
   } ecc_rsp_t;

endpackage

`default_nettype wire
